// ==== hw/lcd_pkg.sv ====
package lcd_pkg;

	// one display write as it sits in the queue
	typedef struct packed {
		logic       rs;   // 0 command, 1 data
		logic [7:0] data;
	} lcd_cmd_t;

	// apb register byte offsets
	localparam logic [3:0] addr_cfg    = 4'h0;
	localparam logic [3:0] addr_ctrl   = 4'h4;
	localparam logic [3:0] addr_txdata = 4'h8;
	localparam logic [3:0] addr_status = 4'hC;

	// cfg word bit positions, msb first
	localparam int cfg_n  = 6; // two lines
	localparam int cfg_f  = 5; // 5x10 font
	localparam int cfg_d  = 4; // display on
	localparam int cfg_c  = 3; // cursor on
	localparam int cfg_b  = 2; // blink on
	localparam int cfg_id = 1; // increment
	localparam int cfg_s  = 0; // shift

	// delays in microseconds, scaled by CLK_PER_US in the controller
	localparam shortint unsigned t_powerup   = 16'd500;
	localparam shortint unsigned t_cmd_gap   = 16'd50;
	localparam shortint unsigned t_clear_gap = 16'd200;
	localparam shortint unsigned t_entry_gap = 16'd100;
	localparam shortint unsigned t_cmd_e     = 16'd10;  // init enable width
	localparam shortint unsigned t_wr_total  = 16'd50;  // full write frame
	localparam shortint unsigned t_wr_setup  = 16'd1;   // rs/data setup before e
	localparam shortint unsigned t_wr_e_end  = 16'd14;  // e falls here

endpackage

// ==== hw/lcd_cmd_if.sv ====
interface lcd_cmd_if;

	logic       valid;
	logic       ready;
	logic       rs;   // register select
	logic [7:0] data;

	modport source (
		output valid,
		output rs,
		output data,
		input  ready
	);

	modport sink (
		input  valid,
		input  rs,
		input  data,
		output ready
	);

endinterface

// ==== hw/lcd_regs.sv ====
module lcd_regs #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [3:0]                  paddr,
	input  logic [31:0]                 pwdata,
	output logic [31:0]                 prdata,
	output logic                        pready,
	output logic                        pslverr,
	lcd_cmd_if.source                   cmd,
	output logic [6:0]                  cfg,
	output logic                        start,
	input  logic                        init_done,
	input  logic                        busy,
	input  logic [$clog2(FIFO_DEPTH):0] level
);

	localparam int lw = $clog2(FIFO_DEPTH) + 1;
	localparam logic [6:0] cfg_reset = 7'h38; // one line 5x10 font with display and cursor on

	logic        access;
	logic        wr_access;
	logic        mapped;
	logic        full;
	logic        tx_valid;
	logic        tx_rs;
	logic [7:0]  tx_data;
	logic [31:0] status;

	assign access    = psel && penable;   // apb access phase
	assign wr_access = access && pwrite;
	assign full      = (level == lw'(FIFO_DEPTH));
	assign pready    = 1'b1;              // no wait states

	always_comb begin
		case (paddr)
			lcd_pkg::addr_cfg,
			lcd_pkg::addr_ctrl,
			lcd_pkg::addr_txdata,
			lcd_pkg::addr_status: mapped = 1'b1;
			default:              mapped = 1'b0;
		endcase
	end

	// a txdata write into a full queue is dropped and flagged
	assign pslverr = access &&
		(!mapped || (pwrite && paddr == lcd_pkg::addr_txdata && !cmd.ready));

	always_comb begin
		status          = '0;
		status[0]       = init_done;
		status[1]       = busy;
		status[2]       = full;
		status[8 +: lw] = level;      // occupancy
	end

	always_comb begin
		case (paddr)
			lcd_pkg::addr_cfg:    prdata = {25'd0, cfg};
			lcd_pkg::addr_status: prdata = status;
			default:              prdata = '0; // ctrl and txdata are write only
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg      <= cfg_reset;
			start    <= 1'b0;
			tx_valid <= 1'b0;
		end else begin
			start    <= wr_access && paddr == lcd_pkg::addr_ctrl && pwdata[0];
			tx_valid <= wr_access && paddr == lcd_pkg::addr_txdata && cmd.ready;
			if (wr_access && paddr == lcd_pkg::addr_cfg) begin
				cfg <= pwdata[6:0];
			end
		end
	end

	// the byte lands in the queue on the cycle after the access phase
	always_ff @(posedge clk) begin
		if (wr_access && paddr == lcd_pkg::addr_txdata) begin
			tx_rs   <= pwdata[8];
			tx_data <= pwdata[7:0];
		end
	end

	assign cmd.valid = tx_valid;
	assign cmd.rs    = tx_rs;
	assign cmd.data  = tx_data;

endmodule

// ==== hw/lcd_cmd_fifo.sv ====
module lcd_cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	lcd_cmd_if.sink                     wr,
	lcd_cmd_if.source                   rd,
	output logic [$clog2(FIFO_DEPTH):0] level
);

	localparam int aw = $clog2(FIFO_DEPTH);
	localparam int lw = aw + 1;

	lcd_pkg::lcd_cmd_t mem [FIFO_DEPTH];
	logic [aw-1:0]     wp;
	logic [aw-1:0]     rp;
	logic [lw-1:0]     count;
	logic              push;
	logic              pop;

	assign wr.ready = (count != lw'(FIFO_DEPTH)); // not full
	assign rd.valid = (count != '0);              // not empty
	assign push     = wr.valid && wr.ready;
	assign pop      = rd.valid && rd.ready;

	assign rd.rs   = mem[rp].rs;
	assign rd.data = mem[rp].data;
	assign level   = count;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wp] <= '{rs: wr.rs, data: wr.data};
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wp    <= '0;
			rp    <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wp <= wp + 1'b1;
			end
			if (pop) begin
				rp <= rp + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== hw/lcd_ctrl.sv ====
module lcd_ctrl #(
	parameter int CLK_PER_US = 20
) (
	input  logic       clk,
	input  logic       rst_n,
	lcd_cmd_if.sink    cmd,
	input  logic [6:0] cfg,
	input  logic       start,
	output logic       init_done,
	output logic       busy,
	output logic       e,
	output logic       rs,
	output logic [7:0] lcd_data
);

	// delays in clock cycles
	localparam int n_powerup   = int'(lcd_pkg::t_powerup) * CLK_PER_US;
	localparam int n_cmd_gap   = int'(lcd_pkg::t_cmd_gap) * CLK_PER_US;
	localparam int n_clear_gap = int'(lcd_pkg::t_clear_gap) * CLK_PER_US;
	localparam int n_entry_gap = int'(lcd_pkg::t_entry_gap) * CLK_PER_US;
	localparam int n_cmd_e     = int'(lcd_pkg::t_cmd_e) * CLK_PER_US;
	localparam int n_wr_total  = int'(lcd_pkg::t_wr_total) * CLK_PER_US;
	localparam int n_wr_setup  = int'(lcd_pkg::t_wr_setup) * CLK_PER_US;
	localparam int n_wr_e_end  = int'(lcd_pkg::t_wr_e_end) * CLK_PER_US;

	// power-up is the longest interval the counter must reach
	localparam int cw = $clog2(n_powerup + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_powerup,
		st_init,
		st_write
	} state_t;

	state_t            state;
	logic [cw-1:0]     cnt;        // cycles within the current interval
	logic [1:0]        step;       // init command index
	logic [cw-1:0]     slot_last;  // last cycle of an init command slot
	logic [7:0]        init_byte;
	lcd_pkg::lcd_cmd_t wr_cmd;
	logic              pop;

	// no pop while starting, or the byte would be lost
	assign cmd.ready = init_done && state == st_idle && !start;
	assign pop       = cmd.valid && cmd.ready;
	assign busy      = (state != st_idle);

	always_comb begin
		case (step)
			2'd2:    slot_last = cw'(n_cmd_e + n_clear_gap - 1); // clear is slow
			2'd3:    slot_last = cw'(n_cmd_e + n_entry_gap - 1);
			default: slot_last = cw'(n_cmd_e + n_cmd_gap - 1);
		endcase
	end

	always_comb begin
		case (step)
			2'd0: init_byte = {4'b0011, cfg[lcd_pkg::cfg_n], cfg[lcd_pkg::cfg_f], 2'b00};
			2'd1: init_byte = {5'b00001, cfg[lcd_pkg::cfg_d], cfg[lcd_pkg::cfg_c],
				cfg[lcd_pkg::cfg_b]};
			2'd2: init_byte = 8'h01; // clear display
			default: init_byte = {6'b000001, cfg[lcd_pkg::cfg_id], cfg[lcd_pkg::cfg_s]};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			cnt       <= '0;
			step      <= '0;
			init_done <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					cnt <= '0;
					if (start) begin
						state <= st_powerup;
					end else if (pop) begin
						state <= st_write;
					end
				end
				st_powerup: begin
					if (cnt == cw'(n_powerup - 1)) begin
						cnt   <= '0;
						step  <= '0;
						state <= st_init;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_init: begin
					if (cnt == slot_last) begin
						cnt <= '0;
						if (step == 2'd3) begin // entry mode was the last one
							init_done <= 1'b1;
							state     <= st_idle;
						end else begin
							step <= step + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_write: begin
					if (cnt == cw'(n_wr_total - 1)) begin
						cnt   <= '0;
						state <= st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			wr_cmd <= '{rs: cmd.rs, data: cmd.data};
		end
	end

	// pins decode from registered state, bus held for the whole slot
	always_comb begin
		e        = 1'b0;
		rs       = 1'b0;
		lcd_data = '0;
		case (state)
			st_init: begin
				e        = (cnt < cw'(n_cmd_e));
				lcd_data = init_byte;
			end
			st_write: begin
				e        = (cnt >= cw'(n_wr_setup)) && (cnt < cw'(n_wr_e_end));
				rs       = wr_cmd.rs;
				lcd_data = wr_cmd.data;
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/lcd_top.sv ====
module lcd_top #(
	parameter int CLK_PER_US = 20,
	parameter int FIFO_DEPTH = 4
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        e,
	output logic        rs,
	output logic [7:0]  lcd_data,
	output logic        busy,
	output logic        init_done
);

	logic [6:0]                  cfg;
	logic                        start;
	logic [$clog2(FIFO_DEPTH):0] level;

	lcd_cmd_if cmd_in ();  // registers to queue
	lcd_cmd_if cmd_out (); // queue to controller

	lcd_regs #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cmd       (cmd_in.source),
		.cfg       (cfg),
		.start     (start),
		.init_done (init_done),
		.busy      (busy),
		.level     (level)
	);

	lcd_cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (cmd_in.sink),
		.rd    (cmd_out.source),
		.level (level)
	);

	lcd_ctrl #(
		.CLK_PER_US (CLK_PER_US)
	) i_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd_out.sink),
		.cfg       (cfg),
		.start     (start),
		.init_done (init_done),
		.busy      (busy),
		.e         (e),
		.rs        (rs),
		.lcd_data  (lcd_data)
	);

endmodule

// ==== sim/tb_lcd_top.sv ====
module tb_lcd_top;

	localparam int clk_per_us = 1;
	localparam int fifo_depth = 4;
	localparam int n_init_e   = 10 * clk_per_us;
	localparam int n_wr_e     = 13 * clk_per_us; // e high from C to 14C-1
	localparam int n_frame    = 50 * clk_per_us;
	localparam int apb_limit  = 20;              // cycles to see pready
	localparam int poll_limit = 1000;            // status reads
	localparam int wait_limit = 3000;            // cycles
	localparam int n_rows     = 11;

	typedef struct packed {
		logic        sync;       // wait for init_done and an empty queue first
		logic [3:0]  addr;
		logic [31:0] wdata;
		logic        exp_err;
		logic        exp_disp;   // byte should reach the display
		logic        chk_status;
		logic [31:0] exp_status;
	} row_t;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        e;
	logic        rs;
	logic [7:0]  lcd_data;
	logic        busy;
	logic        init_done;

	int          errors   = 0;
	int          checks   = 0;
	int          cyc      = 0;
	int          done_cyc = -1;
	int          hi_cnt   = 0;
	int          n_rise   = 0;
	logic        e_q      = 1'b0;
	logic [8:0]  cur_byte = '0;
	logic [8:0]  seen_q [$]; // {rs, data} at each rising e
	int          rise_q [$];
	logic [8:0]  exp_q [$];

	// rows 0..5 go in right after start before init finishes
	row_t rows [n_rows] = '{
		'{1'b0, lcd_pkg::addr_txdata, 32'h148, 1'b0, 1'b1, 1'b0, 32'h0},
		'{1'b0, lcd_pkg::addr_txdata, 32'h169, 1'b0, 1'b1, 1'b0, 32'h0},
		'{1'b0, lcd_pkg::addr_txdata, 32'h080, 1'b0, 1'b1, 1'b0, 32'h0},
		'{1'b0, lcd_pkg::addr_txdata, 32'h121, 1'b0, 1'b1, 1'b0, 32'h0},
		'{1'b0, lcd_pkg::addr_txdata, 32'h155, 1'b1, 1'b0, 1'b0, 32'h0},
		'{1'b0, lcd_pkg::addr_txdata, 32'h1AA, 1'b1, 1'b0, 1'b1, 32'h406}, // full at level 4
		'{1'b1, lcd_pkg::addr_txdata, 32'h14F, 1'b0, 1'b1, 1'b0, 32'h0},
		'{1'b0, 4'h1,                 32'h07F, 1'b1, 1'b0, 1'b0, 32'h0},   // unmapped
		'{1'b0, lcd_pkg::addr_txdata, 32'h0C0, 1'b0, 1'b1, 1'b0, 32'h0},
		'{1'b0, 4'hD,                 32'h000, 1'b1, 1'b0, 1'b0, 32'h0},   // unmapped
		'{1'b0, lcd_pkg::addr_txdata, 32'h14B, 1'b0, 1'b1, 1'b0, 32'h0}
	};

	lcd_top #(
		.CLK_PER_US (clk_per_us),
		.FIFO_DEPTH (fifo_depth)
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.e         (e),
		.rs        (rs),
		.lcd_data  (lcd_data),
		.busy      (busy),
		.init_done (init_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// cfg bits from 6 down are N F D C B ID S
	function automatic logic [7:0] init_cmd_byte(input int idx, input logic [6:0] c);
		case (idx)
			0: return {4'b0011, c[6], c[5], 2'b00};     // function set
			1: return {5'b00001, c[4], c[3], c[2]};     // display control
			2: return 8'h01;                            // clear
			default: return {6'b000001, c[1], c[0]};    // entry mode
		endcase
	endfunction

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk);
		psel    <= 1'b1; // setup phase
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready && waited < apb_limit) begin
			@(posedge clk);
			waited++;
		end
		if (!pready) begin
			errors++;
			$display("ERROR t=%0t APB access to 0x%0h never saw pready", $time, addr);
		end
		compare("pready wait cycles", waited, 0);
		rdata = prdata;
		err   = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rd;
		apb_access(1'b1, addr, data, unused_rd, err);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'h0, data, err);
	endtask

	// polls STATUS until init is done and the queue is empty
	task automatic wait_drained();
		logic [31:0] st;
		logic        err;
		int          polls;
		st    = '0;
		polls = 0;
		while (!(st[0] && st[10:8] == 3'd0) && polls < poll_limit) begin
			apb_read(lcd_pkg::addr_status, st, err);
			polls++;
		end
		if (!(st[0] && st[10:8] == 3'd0)) begin
			errors++;
			$display("ERROR t=%0t init_done with an empty queue never came", $time);
		end
	endtask

	// display bus monitor sampling the settled values of the last cycle
	always @(posedge clk) begin
		if (rst_n) begin
			cyc++;
			if (e && !e_q) begin
				seen_q.push_back({rs, lcd_data});
				rise_q.push_back(cyc);
				cur_byte = {rs, lcd_data};
				if (n_rise >= 5) begin // write frames only
					compare("e frame spacing ok", (cyc - rise_q[n_rise - 1]) >= n_frame, 1);
				end
				n_rise++;
				hi_cnt = 1;
			end else if (e) begin
				hi_cnt++;
				compare("rs/lcd_data steady while e high", {rs, lcd_data}, cur_byte);
			end
			if (!e && e_q) begin
				if (n_rise <= 4) begin
					compare("init e width", hi_cnt, n_init_e);
				end else begin
					compare("write e width", hi_cnt, n_wr_e);
				end
			end
			if (!busy) begin
				compare("idle rs/lcd_data", {rs, lcd_data}, 0);
			end
			if (init_done && done_cyc < 0) begin
				done_cyc = cyc;
			end
			e_q = e;
		end
	end

	initial begin
		logic        err;
		logic [31:0] rdata;
		logic [6:0]  cfg_val;
		int          gap;
		int          waited;

		void'($urandom(41));
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		compare("e", e, 0);
		compare("init_done", init_done, 0);
		apb_read(lcd_pkg::addr_status, rdata, err);
		compare("STATUS", rdata, 0);
		apb_read(lcd_pkg::addr_cfg, rdata, err);
		compare("CFG", rdata, 32'h38);

		// unmapped accesses must not touch CFG
		apb_read(4'h2, rdata, err);
		compare("pslverr unmapped read", err, 1);
		apb_write(4'h1, 32'h7F, err);
		compare("pslverr unmapped write", err, 1);
		apb_read(lcd_pkg::addr_cfg, rdata, err);
		compare("CFG", rdata, 32'h38);

		cfg_val = 7'($urandom % 128);
		apb_write(lcd_pkg::addr_cfg, {25'd0, cfg_val}, err);
		apb_write(lcd_pkg::addr_ctrl, 32'h1, err);
		for (int k = 0; k < 4; k++) begin
			exp_q.push_back({1'b0, init_cmd_byte(k, cfg_val)});
		end

		for (int i = 0; i < n_rows; i++) begin
			if (rows[i].sync) begin
				wait_drained();
			end
			gap = $urandom % 3;
			repeat (gap) @(posedge clk);
			apb_write(rows[i].addr, rows[i].wdata, err);
			compare("pslverr", err, rows[i].exp_err);
			if (rows[i].exp_disp) begin
				exp_q.push_back(rows[i].wdata[8:0]);
			end
			if (rows[i].chk_status) begin
				apb_read(lcd_pkg::addr_status, rdata, err);
				compare("STATUS", rdata, rows[i].exp_status);
			end
		end

		waited = 0;
		while (seen_q.size() < exp_q.size() && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		if (seen_q.size() < exp_q.size()) begin
			errors++;
			$display("ERROR t=%0t only %0d of %0d enable pulses came", $time,
				seen_q.size(), exp_q.size());
		end
		waited = 0;
		while (busy && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		if (busy) begin
			errors++;
			$display("ERROR t=%0t controller never went idle after the last frame", $time);
		end
		repeat (2 * n_frame) @(posedge clk); // room for a stray pulse

		compare("display write count", seen_q.size(), exp_q.size());
		for (int i = 0; i < exp_q.size() && i < seen_q.size(); i++) begin
			compare("display rs/lcd_data", seen_q[i], exp_q[i]);
		end
		if (rise_q.size() >= 4) begin
			compare("init_done after entry gap", done_cyc - rise_q[3], 110 * clk_per_us);
		end
		compare("init_done", init_done, 1);
		apb_read(lcd_pkg::addr_cfg, rdata, err);
		compare("CFG", rdata, {25'd0, cfg_val});
		apb_read(lcd_pkg::addr_status, rdata, err);
		compare("STATUS", rdata, 32'h1);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hw/lcd_pkg.sv
hw/lcd_cmd_if.sv
hw/lcd_regs.sv
hw/lcd_cmd_fifo.sv
hw/lcd_ctrl.sv
hw/lcd_top.sv
sim/tb_lcd_top.sv

// ==== Makefile ====
TB_TOP := tb_lcd_top
LOG    := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f flist.f --top-module lcd_top

obj_dir/V$(TB_TOP): flist.f hw/*.sv sim/*.sv
	verilator --binary -Wno-fatal -f flist.f --top-module $(TB_TOP)

sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
